// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int NUM_REGS = 32
) (
  input  wire                                  clk,
  input  wire                                  rst_n_i,
  input  wire                                  inst_valid_i,
  input  pipe_pkg::word_t                      inst_i,
  input  pipe_pkg::word_t                      rs1_data_i,
  input  pipe_pkg::word_t                      rs2_data_i,
  input  pipe_pkg::res_pkt_t                   ex_fwd_i,
  input  pipe_pkg::res_pkt_t                   wb_fwd_i,
  output logic [pipe_pkg::REG_IDX_W-1:0]       rs1_idx_o,
  output logic [pipe_pkg::REG_IDX_W-1:0]       rs2_idx_o,
  output pipe_pkg::dec_pkt_t                   dec_o
);

  isa_pkg::opcode_e                opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [pipe_pkg::REG_IDX_W-1:0]  rd;
  logic                            use_rs1;
  logic                            use_rs2;
  logic                            bad_enc;
  logic                            bad_idx;
  isa_pkg::alu_op_e                alu_op;
  pipe_pkg::word_t                 imm;
  pipe_pkg::dec_pkt_t              dec_d;

  // map funct3 to the alu op
  // alt picks sub or sra
  function automatic isa_pkg::alu_op_e funct3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      isa_pkg::FUNCT3_ADD_SUB: return alt ? isa_pkg::SUB : isa_pkg::ADD;
      isa_pkg::FUNCT3_SLL:     return isa_pkg::SLL;
      isa_pkg::FUNCT3_SLT:     return isa_pkg::SLT;
      isa_pkg::FUNCT3_SLTU:    return isa_pkg::SLTU;
      isa_pkg::FUNCT3_XOR:     return isa_pkg::XOR;
      isa_pkg::FUNCT3_SRL_SRA: return alt ? isa_pkg::SRA : isa_pkg::SRL;
      isa_pkg::FUNCT3_OR:      return isa_pkg::OR;
      default:                 return isa_pkg::AND;
    endcase
  endfunction

  // execute wins over result, result over the register file
  function automatic pipe_pkg::word_t pick_operand(
    input logic [pipe_pkg::REG_IDX_W-1:0] idx,
    input pipe_pkg::word_t                rf_data,
    input pipe_pkg::res_pkt_t             ex,
    input pipe_pkg::res_pkt_t             wb
  );
    if (idx == '0) return '0;
    if (ex.valid && !ex.illegal && ex.rd == idx) return ex.result;
    if (wb.valid && !wb.illegal && wb.rd == idx) return wb.result;
    return rf_data;
  endfunction

  always_comb begin
    opcode    = isa_pkg::opcode_e'(inst_i[isa_pkg::OPCODE_LSB +: 7]);
    funct3    = inst_i[isa_pkg::FUNCT3_LSB +: 3];
    funct7    = inst_i[isa_pkg::FUNCT7_LSB +: 7];
    rd        = inst_i[isa_pkg::RD_LSB +: pipe_pkg::REG_IDX_W];
    rs1_idx_o = inst_i[isa_pkg::RS1_LSB +: pipe_pkg::REG_IDX_W];
    rs2_idx_o = inst_i[isa_pkg::RS2_LSB +: pipe_pkg::REG_IDX_W];
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    bad_enc   = 1'b0;
    alu_op    = isa_pkg::ADD;
    imm       = '0;
    case (opcode)
      isa_pkg::OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        alu_op  = funct3_to_op(funct3, funct7 == isa_pkg::FUNCT7_ALT);
        // alt form only exists for sub and sra
        bad_enc = !(funct7 == isa_pkg::FUNCT7_BASE ||
                    (funct7 == isa_pkg::FUNCT7_ALT &&
                     (funct3 == isa_pkg::FUNCT3_ADD_SUB || funct3 == isa_pkg::FUNCT3_SRL_SRA)));
      end
      isa_pkg::OP_IMM: begin
        use_rs1 = 1'b1;
        imm     = {{20{inst_i[31]}}, inst_i[31:20]};  // i-type
        alu_op  = funct3_to_op(funct3,
                               funct3 == isa_pkg::FUNCT3_SRL_SRA &&
                               funct7 == isa_pkg::FUNCT7_ALT);
        if (funct3 == isa_pkg::FUNCT3_SLL) begin
          bad_enc = funct7 != isa_pkg::FUNCT7_BASE;
        end else if (funct3 == isa_pkg::FUNCT3_SRL_SRA) begin
          bad_enc = funct7 != isa_pkg::FUNCT7_BASE && funct7 != isa_pkg::FUNCT7_ALT;
        end
      end
      isa_pkg::LUI: begin
        alu_op = isa_pkg::PASS_B;
        imm    = {inst_i[31:12], 12'b0};  // u-type
      end
      default: bad_enc = 1'b1;
    endcase

    // rv32e style file rejects x16..x31
    bad_idx = (rd >= NUM_REGS) ||
              (use_rs1 && rs1_idx_o >= NUM_REGS) ||
              (use_rs2 && rs2_idx_o >= NUM_REGS);

    dec_d.valid     = inst_valid_i;
    dec_d.illegal   = bad_enc || bad_idx;
    dec_d.alu_op    = alu_op;
    dec_d.rd        = rd;
    dec_d.operand_a = pick_operand(rs1_idx_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
    dec_d.operand_b = use_rs2 ? pick_operand(rs2_idx_o, rs2_data_i, ex_fwd_i, wb_fwd_i) : imm;
    dec_d.inst      = inst_i;
  end

  always_ff @(posedge clk) begin
    dec_o <= dec_d;
    if (!rst_n_i) begin
      dec_o.valid <= 1'b0;
    end
  end

  // a valid packet always carries a known operation
  a_dec_op_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    dec_o.valid |-> !$isunknown(dec_o.alu_op));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                 clk,
  input  wire                 rst_n_i,
  input  pipe_pkg::dec_pkt_t  dec_i,
  output pipe_pkg::res_pkt_t  ex_fwd_o,
  output pipe_pkg::res_pkt_t  res_o
);

  pipe_pkg::word_t  op_a;
  pipe_pkg::word_t  op_b;
  logic [4:0]       shamt;
  pipe_pkg::word_t  alu_res;

  assign op_a  = dec_i.operand_a;
  assign op_b  = dec_i.operand_b;
  assign shamt = op_b[4:0];  // rs2[4:0] or imm[4:0]

  always_comb begin
    case (dec_i.alu_op)
      isa_pkg::ADD:    alu_res = op_a + op_b;
      isa_pkg::SUB:    alu_res = op_a - op_b;
      isa_pkg::SLL:    alu_res = op_a << shamt;
      isa_pkg::SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      isa_pkg::SLTU:   alu_res = {31'b0, op_a < op_b};
      isa_pkg::XOR:    alu_res = op_a ^ op_b;
      isa_pkg::SRL:    alu_res = op_a >> shamt;
      isa_pkg::SRA:    alu_res = pipe_pkg::word_t'($signed(op_a) >>> shamt);
      isa_pkg::OR:     alu_res = op_a | op_b;
      isa_pkg::AND:    alu_res = op_a & op_b;
      isa_pkg::PASS_B: alu_res = op_b;  // lui
      default:         alu_res = '0;
    endcase
  end

  // unregistered packet is the first forwarding path back to decode
  always_comb begin
    ex_fwd_o.valid   = dec_i.valid;
    ex_fwd_o.illegal = dec_i.illegal;
    ex_fwd_o.rd      = dec_i.rd;
    ex_fwd_o.result  = alu_res;
    ex_fwd_o.inst    = dec_i.inst;
  end

  always_ff @(posedge clk) begin
    res_o <= ex_fwd_o;
    if (!rst_n_i) begin
      res_o.valid <= 1'b0;
    end
  end

  // a valid result is never unknown
  a_res_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    res_o.valid |-> !$isunknown(res_o.result));

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // reg-reg alu
    OP_IMM = 7'b0010011,  // reg-imm alu
    LUI    = 7'b0110111
  } opcode_e;

  // alu operation carried from decode to execute
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B  // lui, result is operand_b
  } alu_op_e;

  // funct3 codes, shared by OP and OP_IMM
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // sub / sra / srai

  // field positions inside the instruction word
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef logic [31:0] word_t;

  localparam int REG_IDX_W = 5;  // rd / rs field width

  // decode -> execute
  typedef struct packed {
    logic                 valid;
    logic                 illegal;    // unknown encoding or bad reg index
    isa_pkg::alu_op_e     alu_op;
    logic [REG_IDX_W-1:0] rd;
    word_t                operand_a;  // rs1, already forwarded
    word_t                operand_b;  // rs2 or immediate
    word_t                inst;       // raw word, for commit
  } dec_pkt_t;

  // execute -> result, also used as forwarding source
  typedef struct packed {
    logic                 valid;
    logic                 illegal;
    logic [REG_IDX_W-1:0] rd;
    word_t                result;
    word_t                inst;
  } res_pkt_t;

  // a packet only forwards when it will really write rd
  // x0 is excluded by the caller

  // layout note
  // valid sits in the msb of both bundles, payload below it
  // so a whole packet can be loaded at once and valid
  // overridden on reset

endpackage

`default_nettype wire

// File: rtl/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
  parameter int NUM_REGS = 32
) (
  input  wire                                  clk,
  input  wire                                  rst_n_i,
  input  pipe_pkg::res_pkt_t                   res_i,
  input  wire [pipe_pkg::REG_IDX_W-1:0]        rs1_idx_i,
  input  wire [pipe_pkg::REG_IDX_W-1:0]        rs2_idx_i,
  output pipe_pkg::word_t                      rs1_data_o,
  output pipe_pkg::word_t                      rs2_data_o,
  output pipe_pkg::res_pkt_t                   wb_fwd_o,
  output logic                                 commit_valid_o,
  output logic                                 commit_illegal_o,
  output logic [pipe_pkg::REG_IDX_W-1:0]       commit_rd_o,
  output pipe_pkg::word_t                      commit_data_o,
  output pipe_pkg::word_t                      commit_inst_o
);

  pipe_pkg::word_t  regs [NUM_REGS];
  logic             wr_en;

  assign wr_en    = res_i.valid && !res_i.illegal && res_i.rd != '0;
  assign wb_fwd_o = res_i;  // the write landing at the next edge

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[res_i.rd] <= res_i.result;
    end
  end

  // regs[0] stays zero so x0 reads need no special case
  assign rs1_data_o = (rs1_idx_i < NUM_REGS) ? regs[rs1_idx_i] : '0;
  assign rs2_data_o = (rs2_idx_i < NUM_REGS) ? regs[rs2_idx_i] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      commit_valid_o   <= 1'b0;
      commit_illegal_o <= 1'b0;
    end else begin
      commit_valid_o   <= res_i.valid;
      commit_illegal_o <= res_i.valid && res_i.illegal;
    end
  end

  always_ff @(posedge clk) begin
    commit_rd_o   <= res_i.rd;
    commit_data_o <= wr_en ? res_i.result : '0;  // 0 for x0 and illegal
    commit_inst_o <= res_i.inst;
  end

  // x0 is never written
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
    regs[0] == '0);

endmodule

`default_nettype wire

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter int NUM_REGS = 32  // 16 for an rv32e style file
) (
  input  wire                                  clk,
  input  wire                                  rst_n_i,
  input  wire                                  inst_valid_i,
  input  wire [31:0]                           inst_i,
  output logic                                 commit_valid_o,
  output logic                                 commit_illegal_o,
  output logic [pipe_pkg::REG_IDX_W-1:0]       commit_rd_o,
  output logic [31:0]                          commit_data_o,
  output logic [31:0]                          commit_inst_o
);

  pipe_pkg::dec_pkt_t              dec_pkt;
  pipe_pkg::res_pkt_t              ex_fwd;   // execute bypass
  pipe_pkg::res_pkt_t              res_pkt;
  pipe_pkg::res_pkt_t              wb_fwd;   // result bypass
  logic [pipe_pkg::REG_IDX_W-1:0]  rs1_idx;
  logic [pipe_pkg::REG_IDX_W-1:0]  rs2_idx;
  pipe_pkg::word_t                 rs1_data;
  pipe_pkg::word_t                 rs2_data;

  decode_stage #(.NUM_REGS(NUM_REGS)) u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .ex_fwd_i     (ex_fwd),
    .wb_fwd_i     (wb_fwd),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .dec_o        (dec_pkt)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .dec_i    (dec_pkt),
    .ex_fwd_o (ex_fwd),
    .res_o    (res_pkt)
  );

  result_stage #(.NUM_REGS(NUM_REGS)) u_result (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .res_i            (res_pkt),
    .rs1_idx_i        (rs1_idx),
    .rs2_idx_i        (rs2_idx),
    .rs1_data_o       (rs1_data),
    .rs2_data_o       (rs2_data),
    .wb_fwd_o         (wb_fwd),
    .commit_valid_o   (commit_valid_o),
    .commit_illegal_o (commit_illegal_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_inst_o    (commit_inst_o)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f sources.f -o rv_core_sim

# the simulator status is not trusted, the log decides
./obj_dir/rv_core_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sources.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/rv_core_top.sv
tests/tb_clock_gen.sv
tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int          CLK_PERIOD_NS  = 40;
  localparam int          DRIVE_DELAY_NS = 2;
  localparam int          NUM_REGS       = 32;
  localparam int          LATENCY        = 3;  // edges from drive slot to commit
  localparam int          N_IDLE         = 4;
  localparam int          N_DIRECTED     = 11;
  localparam int          N_RANDOM       = 400;
  localparam int          N_SLOTS        = N_IDLE + N_DIRECTED + N_RANDOM;
  localparam int          TIMEOUT_NS     = (N_SLOTS + 20) * CLK_PERIOD_NS;
  localparam logic [31:0] LFSR_SEED      = 32'd46;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  typedef struct packed {
    logic            illegal;
    logic [4:0]      rd;
    pipe_pkg::word_t data;
    pipe_pkg::word_t inst;
    logic [31:0]     due;  // cycle count at which the commit is sampled
  } commit_t;

  logic            clk;
  logic            rst_n;
  logic            inst_valid;
  pipe_pkg::word_t inst;
  logic            commit_valid;
  logic            commit_illegal;
  logic [4:0]      commit_rd;
  pipe_pkg::word_t commit_data;
  pipe_pkg::word_t commit_inst;

  logic [31:0]     cycle_cnt = '0;
  logic [31:0]     lfsr_state = LFSR_SEED;
  pipe_pkg::word_t ref_regs [32];
  commit_t         exp_q [$];

  tb_clock_gen #(
    .PERIOD_NS      (CLK_PERIOD_NS),
    .RESET_CYCLES   (2),
    .DRIVE_DELAY_NS (DRIVE_DELAY_NS)
  ) u_clk_gen (
    .clk     (clk),
    .rst_n_o (rst_n)
  );

  rv_core_top #(.NUM_REGS(NUM_REGS)) dut0 (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .inst_valid_i     (inst_valid),
    .inst_i           (inst),
    .commit_valid_o   (commit_valid),
    .commit_illegal_o (commit_illegal),
    .commit_rd_o      (commit_rd),
    .commit_data_o    (commit_data),
    .commit_inst_o    (commit_inst)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic report_fail(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("MISMATCH at time %0t: %s got 0x%h expected 0x%h", $time, name, got, want);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on mismatch");
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else report_mismatch(name, got, want);
  endtask

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // half the time x0..x3, so hazards show up often
  function automatic logic [4:0] pick_reg();
    if (take_bits(1) != 0) return 5'(take_bits(2));
    return 5'(take_bits(5));
  endfunction

  function automatic pipe_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'(isa_pkg::OP)};
  endfunction

  function automatic pipe_pkg::word_t enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'(isa_pkg::OP_IMM)};
  endfunction

  function automatic pipe_pkg::word_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'(isa_pkg::LUI)};
  endfunction

  // loads, stores, branches, jal, or an M-extension op
  function automatic pipe_pkg::word_t illegal_word();
    logic [6:0] opc;
    if (take_bits(1) != 0) begin
      return enc_r(7'b0000001, 3'(take_bits(3)), pick_reg(), pick_reg(), pick_reg());
    end
    case (take_bits(2))
      0:       opc = 7'b0000011;
      1:       opc = 7'b0100011;
      2:       opc = 7'b1100011;
      default: opc = 7'b1101111;
    endcase
    return {25'(take_bits(25)), opc};
  endfunction

  task automatic random_slot(output logic valid, output pipe_pkg::word_t w);
    logic [3:0]  cls;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    cls   = 4'(take_bits(4));
    valid = 1'b1;
    if (cls == 0) begin
      valid = 1'b0;  // bubble with junk on the bus
      w     = take_bits(32);
    end else if (cls == 1) begin
      w = illegal_word();
    end else if (cls < 4) begin
      w = enc_u(pick_reg(), 20'(take_bits(20)));
    end else if (cls < 10) begin
      f3 = 3'(take_bits(3));
      if (f3 == isa_pkg::FUNCT3_SLL) begin
        imm = {7'b0, 5'(take_bits(5))};
      end else if (f3 == isa_pkg::FUNCT3_SRL_SRA) begin
        f7  = (take_bits(1) != 0) ? isa_pkg::FUNCT7_ALT : isa_pkg::FUNCT7_BASE;
        imm = {f7, 5'(take_bits(5))};
      end else begin
        imm = 12'(take_bits(12));
      end
      w = enc_i(f3, pick_reg(), pick_reg(), imm);
    end else begin
      f3 = 3'(take_bits(3));
      f7 = isa_pkg::FUNCT7_BASE;
      if ((f3 == isa_pkg::FUNCT3_ADD_SUB || f3 == isa_pkg::FUNCT3_SRL_SRA) &&
          take_bits(1) != 0) begin
        f7 = isa_pkg::FUNCT7_ALT;
      end
      w = enc_r(f7, f3, pick_reg(), pick_reg(), pick_reg());
    end
  endtask

  // rv32i alu semantics
  function automatic pipe_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                              input pipe_pkg::word_t a,
                                              input pipe_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? pipe_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // expected commit in program order, updates the model's registers
  function automatic commit_t ref_commit(input pipe_pkg::word_t w, input logic [31:0] due);
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            ill;
    pipe_pkg::word_t res;
    commit_t         e;
    f3  = w[14:12];
    f7  = w[31:25];
    rd  = w[11:7];
    rs1 = w[19:15];
    rs2 = w[24:20];
    res = '0;
    ill = int'(rd) >= NUM_REGS;
    case (w[6:0])
      7'b0110011: begin  // op
        ill = ill || int'(rs1) >= NUM_REGS || int'(rs2) >= NUM_REGS;
        ill = ill || !(f7 == 7'b0000000 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
        res = ref_alu(f3, f7[5], ref_regs[rs1], ref_regs[rs2]);
      end
      7'b0010011: begin  // op-imm
        ill = ill || int'(rs1) >= NUM_REGS;
        if (f3 == 3'b001) ill = ill || f7 != 7'b0000000;
        if (f3 == 3'b101) ill = ill || !(f7 == 7'b0000000 || f7 == 7'b0100000);
        res = ref_alu(f3, f3 == 3'b101 && f7[5], ref_regs[rs1], {{20{w[31]}}, w[31:20]});
      end
      7'b0110111: res = {w[31:12], 12'b0};  // lui
      default:    ill = 1'b1;
    endcase
    if (ill || rd == 0) res = '0;
    else ref_regs[rd] = res;
    e.illegal = ill;
    e.rd      = rd;
    e.data    = res;
    e.inst    = w;
    e.due     = due;
    return e;
  endfunction

  task automatic drive_slot(input logic valid, input pipe_pkg::word_t w);
    @(posedge clk);
    #(DRIVE_DELAY_NS);
    inst_valid = valid;
    inst       = w;
    if (valid) exp_q.push_back(ref_commit(w, cycle_cnt + LATENCY));
  endtask

  // commits sampled away from the rising edge
  always @(negedge clk) begin
    commit_t e;
    if (rst_n === 1'b1) begin
      if (commit_valid === 1'b1) begin
        assert (exp_q.size() > 0) else report_fail("commit seen with no instruction in flight");
        e = exp_q.pop_front();
        check_field("commit cycle", cycle_cnt, e.due);
        check_field("commit_illegal_o", 32'(commit_illegal), 32'(e.illegal));
        check_field("commit_rd_o", 32'(commit_rd), 32'(e.rd));
        check_field("commit_data_o", commit_data, e.data);
        check_field("commit_inst_o", commit_inst, e.inst);
      end else if (exp_q.size() > 0) begin
        assert (exp_q[0].due > cycle_cnt) else report_fail("expected commit did not appear");
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    report_fail("watchdog expired before the test finished");
  end

  initial begin
    logic            valid;
    pipe_pkg::word_t w;
    inst_valid = 1'b0;
    inst       = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    repeat (N_IDLE) drive_slot(1'b0, '0);  // no commits expected here

    // dependency chain at distances 1, 2 and 3, x0 writes, illegal word
    drive_slot(1'b1, enc_i(3'b000, 5'd1, 5'd0, 12'd5));
    drive_slot(1'b1, enc_i(3'b000, 5'd2, 5'd1, -12'sd3));
    drive_slot(1'b1, enc_r(7'b0100000, 3'b000, 5'd3, 5'd1, 5'd2));
    drive_slot(1'b1, enc_r(7'b0000000, 3'b100, 5'd4, 5'd1, 5'd3));
    drive_slot(1'b1, enc_i(3'b000, 5'd0, 5'd4, 12'd77));
    drive_slot(1'b1, enc_r(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd4));
    drive_slot(1'b1, enc_u(5'd6, 20'habcde));
    drive_slot(1'b1, enc_i(3'b101, 5'd7, 5'd6, {7'b0100000, 5'd4}));
    drive_slot(1'b1, enc_r(7'b0000000, 3'b011, 5'd8, 5'd7, 5'd6));
    drive_slot(1'b1, 32'h0000_2083);  // lw x1, leaves x1 alone
    drive_slot(1'b1, enc_r(7'b0000000, 3'b000, 5'd9, 5'd1, 5'd0));

    for (int i = 0; i < N_RANDOM; i++) begin
      random_slot(valid, w);
      drive_slot(valid, w);
    end
    drive_slot(1'b0, '0);
    repeat (LATENCY + 2) @(negedge clk);
    #1;
    if (exp_q.size() != 0) begin
      report_fail($sformatf("%0d instructions never committed", exp_q.size()));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS      = 40,
  parameter int RESET_CYCLES   = 2,
  parameter int DRIVE_DELAY_NS = 2
) (
  output logic clk,
  output logic rst_n_o
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  // reset released just after an edge, like any other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY_NS) rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
